// File: rtl/cp0_defs.svh
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

`define CP0_WORD        32

// Fixed general exception vector, BEV=1 space
`define EXC_VECTOR      32'hBFC0_0380

// Compare starts far away from Count
`define COMPARE_RESET   32'hFFFF_FFFF

// Status fields
`define ST_IE           0
`define ST_EXL          1
`define ST_IM_HI        15
`define ST_IM_LO        8

// Cause fields
`define CA_BD           31
`define CA_IP_HI        15
`define CA_IP_LO        8
`define CA_EXC_HI       6
`define CA_EXC_LO       2

`endif

// File: rtl/excPkg.sv
package excPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Exception codes as written into Cause.ExcCode
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [4:0]
    {
        EXC_INT  = 5'h00,
        EXC_ADEL = 5'h04,
        EXC_ADES = 5'h05,
        EXC_SYS  = 5'h08,
        EXC_BP   = 5'h09,
        EXC_RI   = 5'h0a,
        EXC_OV   = 5'h0c
    } excCodeE;

    ////////////////////////////////////////////////////////////////////////////
    // Exception controller states
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0]
    {
        CTRL_IDLE    = 2'd0,
        CTRL_ENTER   = 2'd1,
        CTRL_HANDLER = 2'd2,
        CTRL_RETURN  = 2'd3
    } ctrlStateE;

endpackage

// File: rtl/cp0RegPkg.sv
package cp0RegPkg;

    ////////////////////////////////////////////////////////////////////////////
    // CP0 register numbers as seen by mtc0/mfc0
    ////////////////////////////////////////////////////////////////////////////
    // Only the registers this subsystem implements
    typedef enum logic [4:0]
    {
        CP0_BADVADDR = 5'd8,
        CP0_COUNT    = 5'd9,
        CP0_COMPARE  = 5'd11,
        CP0_STATUS   = 5'd12,
        CP0_CAUSE    = 5'd13,
        CP0_EPC      = 5'd14
    } cp0RegE;

endpackage

// File: rtl/excDetect.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module excDetect
(
    input  logic                    addressError,
    input  logic                    memRead,
    input  logic                    overflow,
    input  logic                    syscall,
    input  logic                    breakpoint,
    input  logic                    reserved,
    input  logic [`CP0_WORD-1:0]    pc,
    input  logic [`CP0_WORD-1:0]    branchPc,
    input  logic [`CP0_WORD-1:0]    status,
    input  logic [`CP0_WORD-1:0]    cause,
    output logic                    excReq,
    output excPkg::excCodeE         excCode,
    output logic [`CP0_WORD-1:0]    excEpc,
    output logic                    excBd,
    output logic                    badAddrWe
);
    import excPkg::*;

    logic intPending;
    logic anySource;
    logic inDelaySlot;

    // Pending interrupt needs global enable and a matching mask bit
    assign intPending = status[`ST_IE]
                      && (|(cause[`CA_IP_HI:`CA_IP_LO] & status[`ST_IM_HI:`ST_IM_LO]));

    assign anySource = addressError | overflow | syscall | breakpoint | reserved;

    // EXL masks everything while a handler runs
    assign excReq = !status[`ST_EXL] && (anySource || intPending);

    ////////////////////////////////////////////////////////////////////////////
    // Cause priority
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        excCode = EXC_INT;
        if (intPending)
        begin
            excCode = EXC_INT;
        end
        else if (addressError && memRead)
        begin
            excCode = EXC_ADEL;
        end
        else if (reserved)
        begin
            excCode = EXC_RI;
        end
        else if (overflow)
        begin
            excCode = EXC_OV;
        end
        else if (syscall)
        begin
            excCode = EXC_SYS;
        end
        else if (breakpoint)
        begin
            excCode = EXC_BP;
        end
        else if (addressError)
        begin
            excCode = EXC_ADES;
        end
    end

    // BadVAddr only when the winning cause is an address error
    assign badAddrWe = excReq && ((excCode == EXC_ADEL) || (excCode == EXC_ADES));

    // Delay slot instruction restarts at its branch
    assign inDelaySlot = (pc == branchPc);
    assign excEpc      = inDelaySlot ? (pc - `CP0_WORD'd4) : pc;
    assign excBd       = inDelaySlot;

endmodule

// File: rtl/cp0Regs.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module cp0Regs
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    excTake,
    input  logic                    eretTake,
    input  excPkg::excCodeE         excCode,
    input  logic [`CP0_WORD-1:0]    excEpc,
    input  logic                    excBd,
    input  logic                    badAddrWe,
    input  logic [`CP0_WORD-1:0]    badAddr,
    input  logic [5:0]              hwInt,
    input  logic                    timerIrq,
    input  logic                    mtc0,
    input  cp0RegPkg::cp0RegE       regSel,
    input  logic [`CP0_WORD-1:0]    wrData,
    input  logic [`CP0_WORD-1:0]    count,
    input  logic [`CP0_WORD-1:0]    compare,
    output logic [`CP0_WORD-1:0]    status,
    output logic [`CP0_WORD-1:0]    cause,
    output logic [`CP0_WORD-1:0]    epc,
    output logic [`CP0_WORD-1:0]    rdData
);
    import cp0RegPkg::*;

    logic [`CP0_WORD-1:0] badVAddr;
    logic [`CP0_WORD-1:0] statusWr;
    logic                 statusWe;
    logic                 causeWe;
    logic                 epcWe;

    assign statusWe = mtc0 && (regSel == CP0_STATUS);
    assign causeWe  = mtc0 && (regSel == CP0_CAUSE);
    assign epcWe    = mtc0 && (regSel == CP0_EPC);

    // Only IM, EXL and IE are implemented in Status
    always_comb
    begin
        statusWr                        = '0;
        statusWr[`ST_IM_HI:`ST_IM_LO]   = wrData[`ST_IM_HI:`ST_IM_LO];
        statusWr[`ST_EXL]               = wrData[`ST_EXL];
        statusWr[`ST_IE]                = wrData[`ST_IE];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Status and Cause
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            status <= '0;
        end
        else if (excTake)
        begin
            status[`ST_EXL] <= 1'b1;
        end
        else if (eretTake)
        begin
            status[`ST_EXL] <= 1'b0;
        end
        else if (statusWe)
        begin
            status <= statusWr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            cause <= '0;
        end
        else
        begin
            // IP7 shares the top hardware line with the timer
            cause[`CA_IP_HI:(`CA_IP_LO + 2)] <= {hwInt[5] | timerIrq, hwInt[4:0]};
            if (excTake)
            begin
                cause[`CA_BD]                <= excBd;
                cause[`CA_EXC_HI:`CA_EXC_LO] <= excCode;
            end
            else if (causeWe)
            begin
                // Software interrupt bits
                cause[(`CA_IP_LO + 1):`CA_IP_LO] <= wrData[(`CA_IP_LO + 1):`CA_IP_LO];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // EPC and BadVAddr
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (excTake)
        begin
            epc <= excEpc;
        end
        else if (epcWe)
        begin
            epc <= wrData;
        end
    end

    always_ff @(posedge clk)
    begin
        if (excTake && badAddrWe)
        begin
            badVAddr <= badAddr;
        end
    end

    // mfc0 read port
    always_comb
    begin
        case (regSel)
            CP0_BADVADDR: rdData = badVAddr;
            CP0_COUNT:    rdData = count;
            CP0_COMPARE:  rdData = compare;
            CP0_STATUS:   rdData = status;
            CP0_CAUSE:    rdData = cause;
            CP0_EPC:      rdData = epc;
            default:      rdData = '0;
        endcase
    end

    // Entry and return strobes come from one FSM state each
    noTakeAndEret: assert property (@(posedge clk) disable iff (!rstN)
        !(excTake && eretTake))
        else $error("cp0Regs: exception take and eret in the same cycle");

endmodule

// File: rtl/cp0Timer.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module cp0Timer
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    mtc0,
    input  cp0RegPkg::cp0RegE       regSel,
    input  logic [`CP0_WORD-1:0]    wrData,
    output logic [`CP0_WORD-1:0]    count,
    output logic [`CP0_WORD-1:0]    compare,
    output logic                    timerIrq
);
    import cp0RegPkg::*;

    logic countWe;
    logic compareWe;

    assign countWe   = mtc0 && (regSel == CP0_COUNT);
    assign compareWe = mtc0 && (regSel == CP0_COMPARE);

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            count    <= '0;
            compare  <= `COMPARE_RESET;
            timerIrq <= 1'b0;
        end
        else
        begin
            // Free running unless software loads it
            count <= countWe ? wrData : (count + `CP0_WORD'd1);
            if (compareWe)
            begin
                compare <= wrData;
            end
            // Sticky match, acknowledged by any Compare write
            if (compareWe)
            begin
                timerIrq <= 1'b0;
            end
            else if (count == compare)
            begin
                timerIrq <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/excCtrl.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module excCtrl
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    excReq,
    input  logic                    eret,
    input  logic [`CP0_WORD-1:0]    epc,
    output logic                    excTake,
    output logic                    eretTake,
    output logic                    redirect,
    output logic [`CP0_WORD-1:0]    newPc
);
    import excPkg::*;

    ctrlStateE state;
    ctrlStateE nextState;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state <= CTRL_IDLE;
        end
        else
        begin
            state <= nextState;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Next state and strobes
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        nextState = state;
        excTake   = 1'b0;
        eretTake  = 1'b0;
        redirect  = 1'b0;
        newPc     = `EXC_VECTOR;
        case (state)
            CTRL_IDLE:
            begin
                excTake = excReq;
                if (excReq)
                begin
                    nextState = CTRL_ENTER;
                end
            end
            CTRL_ENTER:
            begin
                // Fetch goes to the vector
                redirect  = 1'b1;
                nextState = CTRL_HANDLER;
            end
            CTRL_HANDLER:
            begin
                // eret only counts inside a handler
                eretTake = eret;
                if (eret)
                begin
                    nextState = CTRL_RETURN;
                end
            end
            CTRL_RETURN:
            begin
                redirect  = 1'b1;
                newPc     = epc;
                nextState = CTRL_IDLE;
            end
            default:
            begin
                nextState = CTRL_IDLE;
            end
        endcase
    end

    // Entry and return are always separated by the handler state
    singleRedirect: assert property (@(posedge clk) disable iff (!rstN)
        redirect |=> !redirect)
        else $error("excCtrl: redirect held for two cycles");

endmodule

// File: rtl/cp0Top.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module cp0Top
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    addressError,
    input  logic                    memRead,
    input  logic                    overflow,
    input  logic                    syscall,
    input  logic                    breakpoint,
    input  logic                    reserved,
    input  logic [`CP0_WORD-1:0]    badAddr,
    input  logic [`CP0_WORD-1:0]    pc,
    input  logic [`CP0_WORD-1:0]    branchPc,
    input  logic [5:0]              hwInt,
    input  logic                    eret,
    input  logic                    mtc0,
    input  cp0RegPkg::cp0RegE       regSel,
    input  logic [`CP0_WORD-1:0]    wrData,
    output logic [`CP0_WORD-1:0]    rdData,
    output logic                    redirect,
    output logic [`CP0_WORD-1:0]    newPc,
    output excPkg::excCodeE         excCode,
    output logic                    excTaken
);
    import excPkg::*;

    logic                   excReq;
    excCodeE                detCode;
    logic [`CP0_WORD-1:0]   excEpc;
    logic                   excBd;
    logic                   badAddrWe;
    logic                   eretTake;
    logic [`CP0_WORD-1:0]   status;
    logic [`CP0_WORD-1:0]   cause;
    logic [`CP0_WORD-1:0]   epc;
    logic [`CP0_WORD-1:0]   count;
    logic [`CP0_WORD-1:0]   compare;
    logic                   timerIrq;

    // Recorded cause, not the live prioritizer output
    assign excCode = excCodeE'(cause[`CA_EXC_HI:`CA_EXC_LO]);

    excDetect uDetect
    (
        .addressError (addressError),
        .memRead      (memRead),
        .overflow     (overflow),
        .syscall      (syscall),
        .breakpoint   (breakpoint),
        .reserved     (reserved),
        .pc           (pc),
        .branchPc     (branchPc),
        .status       (status),
        .cause        (cause),
        .excReq       (excReq),
        .excCode      (detCode),
        .excEpc       (excEpc),
        .excBd        (excBd),
        .badAddrWe    (badAddrWe)
    );

    cp0Regs uRegs
    (
        .clk       (clk),
        .rstN      (rstN),
        .excTake   (excTaken),
        .eretTake  (eretTake),
        .excCode   (detCode),
        .excEpc    (excEpc),
        .excBd     (excBd),
        .badAddrWe (badAddrWe),
        .badAddr   (badAddr),
        .hwInt     (hwInt),
        .timerIrq  (timerIrq),
        .mtc0      (mtc0),
        .regSel    (regSel),
        .wrData    (wrData),
        .count     (count),
        .compare   (compare),
        .status    (status),
        .cause     (cause),
        .epc       (epc),
        .rdData    (rdData)
    );

    cp0Timer uTimer
    (
        .clk      (clk),
        .rstN     (rstN),
        .mtc0     (mtc0),
        .regSel   (regSel),
        .wrData   (wrData),
        .count    (count),
        .compare  (compare),
        .timerIrq (timerIrq)
    );

    excCtrl uCtrl
    (
        .clk      (clk),
        .rstN     (rstN),
        .excReq   (excReq),
        .eret     (eret),
        .epc      (epc),
        .excTake  (excTaken),
        .eretTake (eretTake),
        .redirect (redirect),
        .newPc    (newPc)
    );

endmodule

// File: tb/cp0Tb.sv
`timescale 1ns/100ps
`include "cp0_defs.svh"

module cp0Tb;
    import excPkg::*;
    import cp0RegPkg::*;

    localparam int NUM_CASES   = 40;
    localparam int TEST_CYCLES = 8 + NUM_CASES * 14 + 200;
    localparam int TIMEOUT_NS  = TEST_CYCLES * 40 + 1000;

    logic clk = 1'b0;
    logic rstN;
    logic addressError, memRead, overflow, syscall, breakpoint, reserved;
    logic [`CP0_WORD-1:0] badAddr, pc, branchPc, wrData, rdData, newPc;
    logic [5:0] hwInt;
    logic eret, mtc0, redirect, excTaken;
    cp0RegE regSel;
    excCodeE excCode;

    // Model of the CP0 state seen by the reference
    logic mIe, mExl, mBd, mTimerIp;
    logic [7:0] mIm;
    logic [1:0] mSwIp;
    logic [5:0] mHwIp;
    logic [`CP0_WORD-1:0] mEpc, mBadVAddr;
    logic [31:0] rngState = 32'd68;
    int errors = 0;
    int checks = 0;

    cp0Top UUT (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] randWord();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic refIntPending();
        logic [7:0] ip;
        ip = {mHwIp[5] | mTimerIp, mHwIp[4:0], mSwIp};
        return mIe && (|(ip & mIm));
    endfunction

    function automatic logic refReq(logic anySrc);
        return !mExl && (anySrc || refIntPending());
    endfunction

    function automatic excCodeE refCode(logic ae, logic rd, logic ri, logic ov, logic sys,
                                        logic bp);
        if (refIntPending()) return EXC_INT;
        if (ae && rd) return EXC_ADEL;
        if (ri) return EXC_RI;
        if (ov) return EXC_OV;
        if (sys) return EXC_SYS;
        if (bp) return EXC_BP;
        if (ae) return EXC_ADES;
        return EXC_INT;
    endfunction

    // Delay slot restarts at the branch
    function automatic logic [31:0] refEpc(logic [31:0] curPc, logic [31:0] brPc);
        return (curPc == brPc) ? curPc - 32'd4 : curPc;
    endfunction

    task automatic checkBit(logic got, logic exp, string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic checkWord(logic [31:0] got, logic [31:0] exp, string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic checkCode(excCodeE got, excCodeE exp, string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %s expected %s", $time, msg,
                     got.name(), exp.name());
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus-level helpers
    ////////////////////////////////////////////////////////////////////////////
    // IP[7:2] is registered, so the model latches hwInt at the edge too
    task automatic tick();
        @(posedge clk);
        mHwIp = hwInt;
        #2;
    endtask

    task automatic clearSources();
        {addressError, memRead, overflow, syscall, breakpoint, reserved} = '0;
        hwInt = '0;
    endtask

    task automatic writeCp0(cp0RegE sel, logic [31:0] data);
        mtc0 = 1'b1;
        regSel = sel;
        wrData = data;
        tick();
        mtc0 = 1'b0;
        if (sel == CP0_STATUS)
        begin
            mIe = data[`ST_IE];
            mExl = data[`ST_EXL];
            mIm = data[`ST_IM_HI:`ST_IM_LO];
        end
        else if (sel == CP0_CAUSE)
            mSwIp = data[(`CA_IP_LO + 1):`CA_IP_LO];
    endtask

    task automatic readCp0(cp0RegE sel, output logic [31:0] val);
        regSel = sel;
        #1;
        val = rdData;
    endtask

    // Sources are already driven; predicts and checks one edge in CTRL_IDLE
    task automatic takeCheck(output logic taken);
        logic anySrc;
        excCodeE expCode;
        anySrc = addressError | reserved | overflow | syscall | breakpoint;
        taken = refReq(anySrc);
        expCode = refCode(addressError, memRead, reserved, overflow, syscall, breakpoint);
        #1;
        checkBit(excTaken, taken, "take strobe");
        tick();
        checkBit(redirect, taken, "redirect after take");
        if (taken)
        begin
            checkWord(newPc, `EXC_VECTOR, "vector address");
            checkCode(excCode, expCode, "recorded cause");
            mExl = 1'b1;
            mBd = (pc == branchPc);
            mEpc = refEpc(pc, branchPc);
            if (expCode == EXC_ADEL || expCode == EXC_ADES)
                mBadVAddr = badAddr;
        end
    endtask

    task automatic handlerReturn();
        logic [31:0] v;
        clearSources();
        tick();
        checkBit(redirect, 1'b0, "no redirect inside handler");
        readCp0(CP0_EPC, v);
        checkWord(v, mEpc, "EPC");
        readCp0(CP0_CAUSE, v);
        checkBit(v[`CA_BD], mBd, "Cause BD");
        readCp0(CP0_BADVADDR, v);
        checkWord(v, mBadVAddr, "BadVAddr");
        eret = 1'b1;
        tick();
        eret = 1'b0;
        mExl = 1'b0;
        checkBit(redirect, 1'b1, "redirect after eret");
        checkWord(newPc, mEpc, "return address");
        tick();
        checkBit(redirect, 1'b0, "single return redirect");
        readCp0(CP0_STATUS, v);
        checkBit(v[`ST_EXL], 1'b0, "EXL cleared by eret");
    endtask

    task automatic intCase(logic ie, logic [7:0] im, logic [5:0] hw, logic [1:0] sw);
        logic taken;
        writeCp0(CP0_STATUS, 32'h0);
        writeCp0(CP0_CAUSE, {22'h0, sw, 8'h0});
        hwInt = hw;
        tick();
        writeCp0(CP0_STATUS, {16'h0, im, 7'h0, ie});
        takeCheck(taken);
        writeCp0(CP0_CAUSE, 32'h0);
        if (taken)
            handlerReturn();
        else
        begin
            hwInt = '0;
            tick();
        end
    endtask

    initial
    begin
        logic taken;
        logic [31:0] r, v, v2;
        rstN = 1'b0;
        clearSources();
        {eret, mtc0, wrData, badAddr, pc, branchPc} = '0;
        regSel = CP0_STATUS;
        {mIe, mExl, mBd, mTimerIp, mIm, mSwIp, mHwIp, mEpc} = '0;
        mBadVAddr = 'x;
        repeat (8) @(posedge clk);
        #2;
        rstN = 1'b1;
        checkBit(redirect, 1'b0, "redirect after reset");
        readCp0(CP0_COMPARE, v);
        checkWord(v, `COMPARE_RESET, "Compare after reset");

        // Random source mixes with IE set and a random IM
        for (int i = 0; i < NUM_CASES; i++)
        begin
            r = randWord();
            writeCp0(CP0_STATUS, {16'h0, r[31:24], 8'h01});
            hwInt = r[5:0] & r[11:6];
            tick();
            r = randWord();
            {addressError, memRead, reserved} = {r[0] & r[1], r[2], r[3] & r[4]};
            {overflow, syscall, breakpoint} = {r[5] & r[6], r[7] & r[8], r[9] & r[10]};
            v = randWord();
            pc = {v[31:2], 2'b00};
            branchPc = r[11] ? pc : pc + 32'd8;
            badAddr = randWord();
            takeCheck(taken);
            if (taken)
                handlerReturn();
            else
            begin
                clearSources();
                tick();
            end
        end

        intCase(1'b1, 8'h04, 6'b000001, 2'b00);
        intCase(1'b1, 8'h04, 6'b000010, 2'b00);
        intCase(1'b0, 8'hFF, 6'b000001, 2'b00);
        intCase(1'b1, 8'h01, 6'b000000, 2'b01);
        intCase(1'b1, 8'h02, 6'b000000, 2'b01);

        // EXL set by software masks everything
        writeCp0(CP0_STATUS, 32'h0000_FF03);
        {overflow, syscall} = 2'b11;
        takeCheck(taken);
        tick();
        checkBit(redirect, 1'b0, "sources masked by EXL");
        clearSources();
        writeCp0(CP0_STATUS, 32'h0000_FF01);
        eret = 1'b1;
        tick();
        eret = 1'b0;
        checkBit(redirect, 1'b0, "eret outside handler");
        tick();
        checkBit(redirect, 1'b0, "eret outside handler, next cycle");

        ////////////////////////////////////////////////////////////////////////
        // Count/Compare timer
        ////////////////////////////////////////////////////////////////////////
        writeCp0(CP0_STATUS, 32'h0);
        writeCp0(CP0_COUNT, 32'd100);
        readCp0(CP0_COUNT, v);
        checkWord(v, 32'd100, "Count after load");
        tick();
        readCp0(CP0_COUNT, v2);
        checkWord(v2, 32'd101, "Count increments");
        writeCp0(CP0_COMPARE, 32'd110);
        repeat (12) tick();
        readCp0(CP0_COUNT, v);
        checkBit(v > 32'd110, 1'b1, "Count past Compare");
        readCp0(CP0_CAUSE, v);
        checkBit(v[`CA_IP_HI], 1'b1, "timer IP7 set");
        mTimerIp = 1'b1;
        writeCp0(CP0_STATUS, 32'h0000_8001);
        takeCheck(taken);
        writeCp0(CP0_COMPARE, `COMPARE_RESET);
        mTimerIp = 1'b0;
        handlerReturn();
        readCp0(CP0_CAUSE, v);
        checkBit(v[`CA_IP_HI], 1'b0, "IP7 cleared by Compare write");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("The run timed out after %0d ns without finishing", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

endmodule

// File: cp0Sub.f
+incdir+rtl
rtl/excPkg.sv
rtl/cp0RegPkg.sv
rtl/excDetect.sv
rtl/cp0Regs.sv
rtl/cp0Timer.sv
rtl/excCtrl.sv
rtl/cp0Top.sv
tb/cp0Tb.sv
